//--- Bender.yml
package:
  name: dma_write

sources:
  - logic/dma_pkg.sv
  - logic/dma_fifo_if.sv
  - logic/dma_axi_wr_if.sv
  - logic/dma_data_fifo.sv
  - logic/dma_descriptor_queue.sv
  - logic/write_dest_fsm.sv
  - logic/dma_write_top.sv
  - target: test
    files:
      - dv/dma_mem_sink.sv
      - dv/dma_write_tb.sv

//--- compile.f
logic/dma_pkg.sv
logic/dma_fifo_if.sv
logic/dma_axi_wr_if.sv
logic/dma_data_fifo.sv
logic/dma_descriptor_queue.sv
logic/write_dest_fsm.sv
logic/dma_write_top.sv
dv/dma_mem_sink.sv
dv/dma_write_tb.sv

//--- dv/dma_mem_sink.sv
// Memory-side write responder

`timescale 1ns/1ps

module dma_mem_sink (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                awvalid,
   output logic                awready,
   input  dma_pkg::t_addr      awaddr,
   input  dma_pkg::t_burst_len awlen,
   input  logic                wvalid,
   output logic                wready,
   input  dma_pkg::t_data      wdata,
   input  logic                wlast,
   output logic                bvalid,
   input  logic                bready,
   output dma_pkg::t_resp      bresp,
   input  int                  err_burst
);
   import dma_pkg::*;

   t_addr      cap_addr [$];
   t_burst_len cap_len  [$];
   t_data      cap_data [$];
   logic       cap_last [$];

   int   burst_num;
   logic rsp_due;
   logic rsp_taken;

   initial begin
      awready   = 1'b0;
      wready    = 1'b0;
      bvalid    = 1'b0;
      bresp     = OKAY;
      burst_num = 0;
      rsp_due   = 1'b0;
      rsp_taken = 1'b0;
   end

   // capture on the rising edge, where the DUT outputs are settled.
   always @(posedge clk) begin
      if (reset_n) begin
         if (awvalid && awready) begin
            cap_addr.push_back(awaddr);
            cap_len.push_back(awlen);
         end
         if (wvalid && wready) begin
            cap_data.push_back(wdata);
            cap_last.push_back(wlast);
            if (wlast) rsp_due = 1'b1;
         end
         if (bvalid && bready) rsp_taken = 1'b1;
      end
   end

   always @(negedge clk) begin
      if (!reset_n) begin
         awready   = 1'b0;
         wready    = 1'b0;
         bvalid    = 1'b0;
         rsp_due   = 1'b0;
         rsp_taken = 1'b0;
      end else begin
         // each ready is low about one cycle in four.
         awready = ($urandom_range(0, 3) != 0);
         wready  = ($urandom_range(0, 3) != 0);
         if (rsp_taken) begin
            bvalid    = 1'b0;
            bresp     = OKAY;
            rsp_taken = 1'b0;
         end
         if (rsp_due) begin
            bvalid    = 1'b1;
            bresp     = (burst_num == err_burst) ? SLVERR : OKAY;
            burst_num = burst_num + 1;
            rsp_due   = 1'b0;
         end
      end
   end

endmodule

//--- dv/dma_write_tb.sv
// DMA write path testbench

`timescale 1ns/1ps

module dma_write_tb;
   import dma_pkg::*;

   localparam int CLK_PERIOD      = 10;
   localparam int TOTAL_BEATS     = 118;
   localparam int WATCHDOG_CYCLES = 200 * TOTAL_BEATS + 2000;

   logic       clk = 1'b0;
   logic       reset_n;
   logic       desc_push;
   t_addr      desc_dest_addr;
   t_length    desc_length;
   logic       desc_full;
   logic       data_wr_en;
   t_data      data_wr_data;
   logic       data_full;
   logic       awvalid;
   logic       awready;
   t_addr      awaddr;
   t_burst_len awlen;
   logic       wvalid;
   logic       wready;
   t_data      wdata;
   logic       wlast;
   logic       bvalid;
   logic       bready;
   t_resp      bresp;
   logic       reset_dispatcher;
   logic       wr_done;
   logic       busy;
   logic       stopped_on_error;
   t_perf_cntr wr_clk_cnt;
   t_perf_cntr wr_valid_cnt;
   int         err_burst;

   t_addr      exp_addr [$];
   t_burst_len exp_len  [$];
   t_data      exp_data [$];
   int         done_len [$];
   int         expected_len;
   int         done_count  = 0;
   int         error_count = 0;
   int         check_count = 0;

   dma_write_top i_dut (.*);
   dma_mem_sink  i_sink (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      check_count++;
      assert (got === exp) else begin
         error_count++;
         $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // each descriptor is expected as bursts of at most MAX_BURST_BEATS beats.
   task automatic push_desc(input t_addr addr, input int len, input bit fails);
      int    left;
      int    beats;
      t_addr a;
      left = len;
      a    = addr;
      while (left > 0) begin
         beats = (left > MAX_BURST_BEATS) ? MAX_BURST_BEATS : left;
         exp_addr.push_back(a);
         exp_len.push_back(t_burst_len'(beats - 1));
         left = fails ? 0 : left - beats;
         a    = a + MAX_BURST_BEATS * BEAT_BYTES;
      end
      if (!fails) done_len.push_back(len);
      assert (!desc_full) else begin
         error_count++;
         $display("descriptor pushed while the queue was full at %0t", $time);
      end
      desc_push      = 1'b1;
      desc_dest_addr = addr;
      desc_length    = t_length'(len);
      @(negedge clk);
      desc_push = 1'b0;
   endtask

   // only the first n_model words are expected to reach the memory side.
   task automatic push_payload(input int len, input int n_model);
      t_data word;
      for (int i = 0; i < len; i++) begin
         word = $urandom;
         if (i < n_model) exp_data.push_back(word);
         repeat ($urandom_range(0, 4)) @(negedge clk);
         while (data_full) @(negedge clk);
         data_wr_en   = 1'b1;
         data_wr_data = word;
         @(negedge clk);
         data_wr_en = 1'b0;
      end
   endtask

   task automatic wait_for_done(input int n);
      while (done_count < n || busy) @(negedge clk);
   endtask

   task automatic check_captured();
      int beat;
      compare_value("burst count", i_sink.cap_addr.size(), exp_addr.size());
      compare_value("beat count", i_sink.cap_data.size(), exp_data.size());
      for (int i = 0; i < exp_addr.size() && i < i_sink.cap_addr.size(); i++) begin
         compare_value($sformatf("awaddr of burst %0d", i), i_sink.cap_addr[i], exp_addr[i]);
         compare_value($sformatf("awlen of burst %0d", i), i_sink.cap_len[i], exp_len[i]);
      end
      for (int i = 0; i < exp_data.size() && i < i_sink.cap_data.size(); i++) begin
         compare_value($sformatf("wdata of beat %0d", i), i_sink.cap_data[i], exp_data[i]);
      end
      // walk the captured beats burst by burst against each captured awlen.
      beat = 0;
      for (int b = 0; b < i_sink.cap_len.size(); b++) begin
         for (int j = 0; j <= int'(i_sink.cap_len[b]); j++) begin
            if (beat < i_sink.cap_last.size()) begin
               compare_value($sformatf("wlast of beat %0d", beat), i_sink.cap_last[beat],
                             j == int'(i_sink.cap_len[b]));
            end
            beat++;
         end
      end
   endtask

   // every wr_done closes the oldest descriptor still expected to complete.
   always @(posedge clk) begin
      if (reset_n && wr_done) begin
         assert (done_len.size() != 0) else begin
            error_count++;
            $display("wr_done pulsed with no descriptor expected to complete");
         end
         if (done_len.size() != 0) begin
            expected_len = done_len.pop_front();
            compare_value("wr_valid_cnt at wr_done", wr_valid_cnt, expected_len);
            check_count++;
            assert (wr_clk_cnt >= expected_len) else begin
               error_count++;
               $display("[ERROR] %0t: wr_clk_cnt %0d below length %0d",
                        $time, wr_clk_cnt, expected_len);
            end
            done_count++;
         end
      end
   end

   a_aw_held : assert property (
      @(posedge clk) disable iff (!reset_n)
      awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen)
   ) else begin
      error_count++;
      $display("[ERROR] %0t: write address dropped or changed before awready", $time);
   end

   a_w_held : assert property (
      @(posedge clk) disable iff (!reset_n)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast)
   ) else begin
      error_count++;
      $display("[ERROR] %0t: write data dropped or changed before wready", $time);
   end

   a_done_on_okay : assert property (
      @(posedge clk) disable iff (!reset_n)
      wr_done |-> bvalid && bready && (bresp == OKAY)
   ) else begin
      error_count++;
      $display("[ERROR] %0t: wr_done without an OKAY response handshake", $time);
   end

   a_no_aw_when_stopped : assert property (
      @(posedge clk) disable iff (!reset_n)
      stopped_on_error |-> !awvalid
   ) else begin
      error_count++;
      $display("[ERROR] %0t: awvalid raised while stopped on error", $time);
   end

   initial begin
      void'($urandom(32'h3888_7288));
      reset_n          = 1'b0;
      desc_push        = 1'b0;
      desc_dest_addr   = '0;
      desc_length      = '0;
      data_wr_en       = 1'b0;
      data_wr_data     = '0;
      reset_dispatcher = 1'b0;
      err_burst        = -1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset_n = 1'b1;

      push_desc(32'h0000_1000, 1, 1'b0);
      push_desc(32'h0000_2000, 16, 1'b0);
      push_desc(32'h0000_3040, 17, 1'b0);
      push_desc(32'h0000_4100, 40, 1'b0);
      push_payload(74, 74);
      wait_for_done(4);

      // the first burst of this descriptor is answered with SLVERR.
      err_burst = exp_addr.size();
      push_desc(32'h0000_8000, 24, 1'b1);
      push_payload(24, 16);
      while (!stopped_on_error) @(negedge clk);
      // eight words of the failed descriptor are left, so this tops the FIFO up.
      push_payload(DATA_DEPTH - 8, 0);
      compare_value("data_full with the FIFO filled", data_full, 1);
      repeat (8) @(negedge clk);
      compare_value("stopped_on_error while held", stopped_on_error, 1);
      reset_dispatcher = 1'b1;
      @(negedge clk);
      reset_dispatcher = 1'b0;
      compare_value("stopped_on_error after clear", stopped_on_error, 0);
      compare_value("busy after clear", busy, 0);
      compare_value("data_full after flush", data_full, 0);

      push_desc(32'h0000_9004, 20, 1'b0);
      push_payload(20, 20);
      wait_for_done(5);

      check_captured();
      compare_value("wr_done count", done_count, 5);
      compare_value("busy at end", busy, 0);
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles without the tests finishing",
               WATCHDOG_CYCLES);
      $display("checks: %0d, errors: %0d", check_count, error_count);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- logic/dma_axi_wr_if.sv
// AXI write channels

`timescale 1ns/1ps

interface dma_axi_wr_if;
   import dma_pkg::*;

   logic       awvalid;
   logic       awready;
   t_addr      awaddr;
   t_burst_len awlen;

   logic       wvalid;
   logic       wready;
   t_data      wdata;
   logic       wlast;

   logic       bvalid;
   logic       bready;
   t_resp      bresp;

   modport to_sink (
      output awvalid, awaddr, awlen, wvalid, wdata, wlast, bready,
      input  awready, wready, bvalid, bresp
   );

   // the memory side of the same channels, as seen from the top level pins.
   modport to_port (
      input  awvalid, awaddr, awlen, wvalid, wdata, wlast, bready,
      output awready, wready, bvalid, bresp
   );

endinterface

//--- logic/dma_data_fifo.sv
// Payload data FIFO

`timescale 1ns/1ps

module dma_data_fifo (
   input  logic           clk,
   input  logic           reset_n,
   input  logic           wr_en,
   input  dma_pkg::t_data wr_data,
   output logic           full,
   dma_fifo_if.fifo_side  fifo
);
   import dma_pkg::*;

   t_data                         mem [DATA_DEPTH];
   logic [$clog2(DATA_DEPTH)-1:0] wr_ptr;
   logic [$clog2(DATA_DEPTH)-1:0] rd_ptr;
   logic [$clog2(DATA_DEPTH):0]   count;
   logic                          do_wr;
   logic                          do_rd;

   // the depth is a power of two, so the top count bit alone means full.
   assign full           = count[$clog2(DATA_DEPTH)];
   assign fifo.not_empty = (count != '0);
   assign fifo.rd_data   = mem[rd_ptr];

   assign do_wr = wr_en & ~full;
   assign do_rd = fifo.rd_en;

   always_ff @(posedge clk) begin
      if (!reset_n || fifo.flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // the reader may only pop a word that is really there.
   a_no_read_when_empty : assert property (
      @(posedge clk) disable iff (!reset_n)
      fifo.rd_en |-> fifo.not_empty
   );

endmodule

//--- logic/dma_descriptor_queue.sv
// Descriptor queue

`timescale 1ns/1ps

module dma_descriptor_queue (
   input  logic             clk,
   input  logic             reset_n,
   input  logic             push,
   input  dma_pkg::t_addr   dest_addr,
   input  dma_pkg::t_length length,
   output logic             full,
   output logic             not_empty,
   output dma_pkg::t_addr   head_dest_addr,
   output dma_pkg::t_length head_length,
   input  logic             pop
);
   import dma_pkg::*;

   t_addr                         addr_mem [DESC_DEPTH];
   t_length                       len_mem  [DESC_DEPTH];
   logic [$clog2(DESC_DEPTH)-1:0] wr_ptr;
   logic [$clog2(DESC_DEPTH)-1:0] rd_ptr;
   logic [$clog2(DESC_DEPTH):0]   count;
   logic                          do_push;

   assign full           = count[$clog2(DESC_DEPTH)];
   assign not_empty      = (count != '0);
   assign head_dest_addr = addr_mem[rd_ptr];
   assign head_length    = len_mem[rd_ptr];

   // a push into a full queue is dropped.
   assign do_push = push & ~full;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         addr_mem[wr_ptr] <= dest_addr;
         len_mem[wr_ptr]  <= length;
      end
   end

   a_no_pop_when_empty : assert property (
      @(posedge clk) disable iff (!reset_n)
      pop |-> not_empty
   );

endmodule

//--- logic/dma_fifo_if.sv
// Data FIFO read interface

`timescale 1ns/1ps

interface dma_fifo_if;
   import dma_pkg::*;

   logic  not_empty;
   t_data rd_data;
   logic  rd_en;
   logic  flush;

   modport fifo_side (
      output not_empty,
      output rd_data,
      input  rd_en,
      input  flush
   );

   modport rd_out (
      input  not_empty,
      input  rd_data,
      output rd_en,
      output flush
   );

endinterface

//--- logic/dma_pkg.sv
// DMA write path shared definitions

package dma_pkg;

   // datapath and descriptor widths.
   localparam int DATA_W      = 32;
   localparam int ADDR_W      = 32;
   localparam int LENGTH_W    = 16;
   localparam int BURST_LEN_W = 8;
   localparam int PERF_CNTR_W = 32;

   // burst geometry; one beat always moves a full data word.
   localparam int MAX_BURST_BEATS = 16;
   localparam int BEAT_BYTES      = DATA_W / 8;

   // storage depths, both powers of two.
   localparam int DESC_DEPTH = 4;
   localparam int DATA_DEPTH = 32;

   typedef logic [DATA_W-1:0]      t_data;
   typedef logic [ADDR_W-1:0]      t_addr;
   typedef logic [LENGTH_W-1:0]    t_length;
   typedef logic [BURST_LEN_W-1:0] t_burst_len;
   typedef logic [PERF_CNTR_W-1:0] t_perf_cntr;

   // write response codes as carried on bresp.
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } t_resp;

   typedef enum logic [2:0] {
      IDLE       = 3'd0,
      ADDR_SETUP = 3'd1,
      WAIT_DATA  = 3'd2,
      WRITE_DATA = 3'd3,
      WAIT_RSP   = 3'd4,
      ERROR      = 3'd5
   } t_wr_state;

endpackage

//--- logic/dma_write_top.sv
// DMA write path top level

`timescale 1ns/1ps

module dma_write_top (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                desc_push,
   input  dma_pkg::t_addr      desc_dest_addr,
   input  dma_pkg::t_length    desc_length,
   output logic                desc_full,
   input  logic                data_wr_en,
   input  dma_pkg::t_data      data_wr_data,
   output logic                data_full,
   output logic                awvalid,
   input  logic                awready,
   output dma_pkg::t_addr      awaddr,
   output dma_pkg::t_burst_len awlen,
   output logic                wvalid,
   input  logic                wready,
   output dma_pkg::t_data      wdata,
   output logic                wlast,
   input  logic                bvalid,
   output logic                bready,
   input  dma_pkg::t_resp      bresp,
   input  logic                reset_dispatcher,
   output logic                wr_done,
   output logic                busy,
   output logic                stopped_on_error,
   output dma_pkg::t_perf_cntr wr_clk_cnt,
   output dma_pkg::t_perf_cntr wr_valid_cnt
);
   import dma_pkg::*;

   logic    desc_not_empty;
   logic    desc_pop;
   t_addr   head_dest_addr;
   t_length head_length;

   dma_fifo_if   data_if ();
   dma_axi_wr_if axi_if ();

   dma_descriptor_queue i_desc_queue (
      .clk            (clk),
      .reset_n        (reset_n),
      .push           (desc_push),
      .dest_addr      (desc_dest_addr),
      .length         (desc_length),
      .full           (desc_full),
      .not_empty      (desc_not_empty),
      .head_dest_addr (head_dest_addr),
      .head_length    (head_length),
      .pop            (desc_pop)
   );

   dma_data_fifo i_data_fifo (
      .clk     (clk),
      .reset_n (reset_n),
      .wr_en   (data_wr_en),
      .wr_data (data_wr_data),
      .full    (data_full),
      .fifo    (data_if.fifo_side)
   );

   write_dest_fsm i_wr_fsm (
      .clk              (clk),
      .reset_n          (reset_n),
      .desc_not_empty   (desc_not_empty),
      .head_dest_addr   (head_dest_addr),
      .head_length      (head_length),
      .desc_pop         (desc_pop),
      .rd_fifo          (data_if.rd_out),
      .dest_mem         (axi_if.to_sink),
      .reset_dispatcher (reset_dispatcher),
      .wr_done          (wr_done),
      .busy             (busy),
      .stopped_on_error (stopped_on_error),
      .wr_clk_cnt       (wr_clk_cnt),
      .wr_valid_cnt     (wr_valid_cnt)
   );

   // memory side of the write channels mapped onto the pins.
   assign awvalid       = axi_if.awvalid;
   assign awaddr        = axi_if.awaddr;
   assign awlen         = axi_if.awlen;
   assign axi_if.awready = awready;
   assign wvalid        = axi_if.wvalid;
   assign wdata         = axi_if.wdata;
   assign wlast         = axi_if.wlast;
   assign axi_if.wready = wready;
   assign axi_if.bvalid = bvalid;
   assign axi_if.bresp  = bresp;
   assign bready        = axi_if.bready;

endmodule

//--- logic/write_dest_fsm.sv
// Write destination engine
// Splits descriptors into AXI write bursts fed from the data FIFO.

`timescale 1ns/1ps

module write_dest_fsm (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                desc_not_empty,
   input  dma_pkg::t_addr      head_dest_addr,
   input  dma_pkg::t_length    head_length,
   output logic                desc_pop,
   dma_fifo_if.rd_out          rd_fifo,
   dma_axi_wr_if.to_sink       dest_mem,
   input  logic                reset_dispatcher,
   output logic                wr_done,
   output logic                busy,
   output logic                stopped_on_error,
   output dma_pkg::t_perf_cntr wr_clk_cnt,
   output dma_pkg::t_perf_cntr wr_valid_cnt
);
   import dma_pkg::*;

   t_wr_state  state;
   t_wr_state  next_state;

   t_addr      cur_addr;
   t_length    remaining;
   t_burst_len beat_cnt;

   t_addr      src_addr;
   t_length    src_len;
   t_length    burst_beats;

   logic       aw_hs;
   logic       w_hs;
   logic       b_hs;
   logic       rsp_err;
   logic       load_desc;
   logic       next_burst;
   logic       last_rsp_ok;

   assign aw_hs   = dest_mem.awvalid & dest_mem.awready;
   assign w_hs    = dest_mem.wvalid & dest_mem.wready;
   assign b_hs    = dest_mem.bvalid & dest_mem.bready;
   assign rsp_err = (dest_mem.bresp == SLVERR) || (dest_mem.bresp == DECERR);

   assign load_desc   = (state == IDLE) && desc_not_empty;
   assign next_burst  = load_desc || (b_hs && !rsp_err && (remaining != '0));
   assign last_rsp_ok = b_hs && !rsp_err && (remaining == '0);

   // the first burst comes from the queue head, later ones from the running state.
   assign src_addr    = (state == IDLE) ? head_dest_addr : cur_addr;
   assign src_len     = (state == IDLE) ? head_length : remaining;
   assign burst_beats = (src_len > t_length'(MAX_BURST_BEATS)) ?
                        t_length'(MAX_BURST_BEATS) : src_len;

   always_comb begin
      next_state = state;
      unique case (state)
         IDLE: begin
            if (desc_not_empty) next_state = ADDR_SETUP;
         end
         ADDR_SETUP: begin
            if (aw_hs) next_state = WAIT_DATA;
         end
         WAIT_DATA: begin
            if (rd_fifo.not_empty) next_state = WRITE_DATA;
         end
         WRITE_DATA: begin
            if (w_hs && dest_mem.wlast) next_state = WAIT_RSP;
         end
         WAIT_RSP: begin
            if (b_hs) begin
               if (rsp_err) begin
                  next_state = ERROR;
               end else if (remaining != '0) begin
                  next_state = ADDR_SETUP;
               end else begin
                  next_state = IDLE;
               end
            end
         end
         ERROR: begin
            if (reset_dispatcher) next_state = IDLE;
         end
         default: next_state = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state            <= IDLE;
         dest_mem.awvalid <= 1'b0;
         dest_mem.awlen   <= '0;
         remaining        <= '0;
         beat_cnt         <= '0;
         wr_clk_cnt       <= '0;
         wr_valid_cnt     <= '0;
      end else begin
         state <= next_state;

         if (next_burst) begin
            dest_mem.awvalid <= 1'b1;
            dest_mem.awlen   <= t_burst_len'(burst_beats - 1'b1);
            remaining        <= src_len - burst_beats;
            beat_cnt         <= '0;
         end else if (aw_hs) begin
            dest_mem.awvalid <= 1'b0;
         end

         // the count stops on the last beat so it can be checked against awlen.
         if (w_hs && !dest_mem.wlast) begin
            beat_cnt <= beat_cnt + 1'b1;
         end

         if (load_desc) begin
            wr_clk_cnt   <= '0;
            wr_valid_cnt <= '0;
         end else begin
            if (state == WRITE_DATA) begin
               wr_clk_cnt <= wr_clk_cnt + 1'b1;
            end
            if (w_hs) begin
               wr_valid_cnt <= wr_valid_cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (next_burst) begin
         dest_mem.awaddr <= src_addr;
         cur_addr        <= src_addr + t_addr'(MAX_BURST_BEATS * BEAT_BYTES);
      end
   end

   assign dest_mem.wvalid = (state == WRITE_DATA) && rd_fifo.not_empty;
   assign dest_mem.wdata  = rd_fifo.rd_data;
   assign dest_mem.wlast  = dest_mem.wvalid && (beat_cnt == dest_mem.awlen);
   assign dest_mem.bready = (state == WAIT_RSP);
   assign rd_fifo.rd_en   = w_hs;

   // leaving the error state drops the failed descriptor and its leftover data.
   assign rd_fifo.flush    = (state == ERROR) && reset_dispatcher;
   assign desc_pop         = last_rsp_ok || rd_fifo.flush;
   assign wr_done          = last_rsp_ok;
   assign busy             = (state != IDLE);
   assign stopped_on_error = (state == ERROR);

   a_aw_hold : assert property (
      @(posedge clk) disable iff (!reset_n)
      dest_mem.awvalid && !dest_mem.awready |=>
         dest_mem.awvalid && $stable(dest_mem.awaddr) && $stable(dest_mem.awlen)
   );

   // a stalled beat keeps its word and its last marker until accepted.
   a_w_hold : assert property (
      @(posedge clk) disable iff (!reset_n)
      dest_mem.wvalid && !dest_mem.wready |=>
         dest_mem.wvalid && $stable(dest_mem.wdata) && $stable(dest_mem.wlast)
   );

   a_beat_cnt_in_burst : assert property (
      @(posedge clk) disable iff (!reset_n)
      beat_cnt <= dest_mem.awlen
   );

endmodule
